/* xc_cfg.svh */
// ####################
// Correlator build constants
// Line and lag counts, counter width
// Header field widths and frame length
// ####################

`ifndef XC_CFG_SVH
`define XC_CFG_SVH

`define XC_NUM_LINES    4   // Input lines, one lane each
`define XC_LAG_AUTO     4   // Auto lags 0..LAG_AUTO-1
`define XC_RESOLUTION   16  // Coincidence counter bits

// Header fields
`define XC_TOTAL_BITS   16
`define XC_GEOM_BITS    16
`define XC_HDR_BITS     (`XC_TOTAL_BITS + `XC_GEOM_BITS)

`define XC_FRAME_NIBBLES \
	((`XC_HDR_BITS + `XC_NUM_LINES * (`XC_LAG_AUTO + 1) * `XC_RESOLUTION) / 4)

`endif

/* xc_types_pkg.sv */
// ####################
// Sample and count types
// shared by sampler, lanes and packer
// ####################

`include "xc_cfg.svh"

package xc_types_pkg;

	// One bit per input line, after inversion
	typedef logic [`XC_NUM_LINES-1:0] sample_t;

	// Single coincidence counter
	typedef logic [`XC_RESOLUTION-1:0] count_t;

	// Auto counts of one lane, lag k in element k
	typedef count_t [`XC_LAG_AUTO-1:0] lag_counts_t;

endpackage

/* xc_frame_pkg.sv */
// ####################
// Frame side types
// nibble and header fields
// ####################

`include "xc_cfg.svh"

package xc_frame_pkg;

	typedef logic [3:0] nibble_t;   // One output nibble

	typedef logic [`XC_TOTAL_BITS-1:0] sample_total_t;  // Samples in the window

	typedef struct packed {
		logic [`XC_GEOM_BITS/2-1:0] lines;
		logic [`XC_GEOM_BITS/2-1:0] lags;
	} geometry_t;

endpackage

/* xc_sampler.sv */
// ####################
// Input sampler
// Line capture with inversion
// Window start and end pulses
// ####################

`timescale 1ns/1ns

module xc_sampler (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic                  smp_en,
	input  xc_types_pkg::sample_t line_in,
	input  xc_types_pkg::sample_t invert,
	input  logic                  integrate,
	output xc_types_pkg::sample_t sample,
	output logic                  sample_valid,
	output logic                  counting,
	output logic                  win_start,
	output logic                  win_end
);

	logic prev_counting;    // Counting level of the previous sample

	// Sample payload
	always_ff @(posedge intclk) begin
		if (smp_en)
			sample <= line_in ^ invert;
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			sample_valid  <= 1'b0;
			counting      <= 1'b0;
			prev_counting <= 1'b0;
			win_start     <= 1'b0;
			win_end       <= 1'b0;
		end else begin
			sample_valid <= smp_en;
			// counting still holds the last sample's level here
			win_start    <= smp_en & integrate & ~counting;
			if (smp_en)
				counting <= integrate;
			if (sample_valid)
				prev_counting <= counting;
			// First low sample after a high one closes the window
			win_end <= sample_valid & ~counting & prev_counting;
		end
	end

	// Start and end must never coincide
	a_start_end_apart: assert property (@(posedge intclk) disable iff (!rst_n)
		!(win_start && win_end))
		else $error("win_start and win_end high in the same cycle");

endmodule

/* xc_lane.sv */
// ####################
// Correlation lane
// Delay line of past bits
// Saturating auto and cross counters
// ####################

`timescale 1ns/1ns

`include "xc_cfg.svh"

module xc_lane (
	input  logic                      intclk,
	input  logic                      rst_n,
	input  logic                      sample_bit,
	input  logic                      neighbour_bit,
	input  logic                      sample_valid,
	input  logic                      counting,
	input  logic                      win_start,
	output xc_types_pkg::lag_counts_t auto_counts,
	output xc_types_pkg::count_t      cross_count
);

	localparam int LAG = `XC_LAG_AUTO;

	logic [LAG-1:1]       hist;     // hist[k] is the bit from k samples ago
	logic [LAG-1:0]       taps;     // Current bit at tap 0
	logic [LAG:0]         hit;      // Top bit is the cross coincidence
	xc_types_pkg::count_t cnt [0:LAG];

	assign taps = {hist, sample_bit};

	always_comb begin
		hit[LAG-1:0] = taps & {LAG{sample_bit}};
		hit[LAG]     = sample_bit & neighbour_bit;
	end

	// Delay line runs on every sample, windowed or not
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n)
			hist <= '0;
		else if (sample_valid)
			hist <= {hist[LAG-2:1], sample_bit};
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k <= LAG; k++)
				cnt[k] <= '0;
		end else if (sample_valid) begin
			for (int k = 0; k <= LAG; k++) begin
				if (win_start)
					cnt[k] <= xc_types_pkg::count_t'(hit[k]);  // Clear, then count this sample
				else if (counting && hit[k] && cnt[k] != '1)
					cnt[k] <= cnt[k] + 1'b1;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < LAG; k++)
			auto_counts[k] = cnt[k];
		cross_count = cnt[LAG];
	end

	// Counts only ever drop through a window restart
	for (genvar k = 0; k <= LAG; k++) begin : g_mono
		a_no_decrease: assert property (@(posedge intclk) disable iff (!rst_n)
			(cnt[k] < $past(cnt[k])) |-> $past(win_start))
			else $error("counter %0d decreased outside win_start", k);
	end

endmodule

/* xc_packer.sv */
// ####################
// Frame packer
// Window sample count, count snapshot
// Nibble stream, MSB first
// ####################

`timescale 1ns/1ns

`include "xc_cfg.svh"

module xc_packer (
	input  logic                                   intclk,
	input  logic                                   rst_n,
	input  logic                                   sample_valid,
	input  logic                                   counting,
	input  logic                                   win_end,
	input  logic [`XC_NUM_LINES*`XC_LAG_AUTO*`XC_RESOLUTION-1:0] auto_flat,
	input  logic [`XC_NUM_LINES*`XC_RESOLUTION-1:0] cross_flat,
	output xc_frame_pkg::nibble_t                  tx_nibble,
	output logic                                   tx_busy,
	output logic                                   tx_strobe,
	output logic                                   tx_done
);

	localparam int RES          = `XC_RESOLUTION;
	localparam int LAG          = `XC_LAG_AUTO;
	localparam int FRAME_NIBBLES = `XC_FRAME_NIBBLES;
	localparam int FRAME_BITS   = FRAME_NIBBLES * 4;
	localparam int NIB_W        = $clog2(FRAME_NIBBLES + 1);
	localparam logic [NIB_W-1:0] NIB_LAST = NIB_W'(FRAME_NIBBLES);
	localparam logic [NIB_W-1:0] NIB_PEN  = NIB_W'(FRAME_NIBBLES - 1);

	xc_frame_pkg::sample_total_t smp_total;
	xc_frame_pkg::geometry_t     geometry;
	xc_types_pkg::count_t        field;
	logic [FRAME_BITS-1:0]       frame_next;
	logic [FRAME_BITS-1:0]       frame;         // Remaining nibbles with the next one on top
	logic [NIB_W-1:0]            nib_cnt;       // Nibbles sent so far
	logic                        accept;

	assign geometry.lines = (`XC_GEOM_BITS/2)'(`XC_NUM_LINES);
	assign geometry.lags  = (`XC_GEOM_BITS/2)'(`XC_LAG_AUTO);
	assign accept         = win_end & ~tx_busy;   // Late window ends are dropped

	// Samples inside the current window
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n)
			smp_total <= '0;
		else if (win_end)
			smp_total <= xc_frame_pkg::sample_total_t'(sample_valid & counting);
		else if (sample_valid && counting && smp_total != '1)
			smp_total <= smp_total + 1'b1;
	end

	// Header on top, then each lane's lag counts followed by its cross count
	always_comb begin
		frame_next = '0;
		field      = '0;
		frame_next[`XC_HDR_BITS-1:0] = {smp_total, geometry};
		for (int i = 0; i < `XC_NUM_LINES; i++) begin
			for (int k = 0; k <= LAG; k++) begin
				if (k < LAG)
					field = auto_flat[(i*LAG + k)*RES +: RES];
				else
					field = cross_flat[i*RES +: RES];
				frame_next = {frame_next[FRAME_BITS-RES-1:0], field};
			end
		end
	end

	// Frame payload
	always_ff @(posedge intclk) begin
		if (accept) begin
			tx_nibble <= frame_next[FRAME_BITS-1 -: 4];
			frame     <= {frame_next[FRAME_BITS-5:0], 4'h0};
		end else if (tx_busy && nib_cnt != NIB_LAST) begin
			tx_nibble <= frame[FRAME_BITS-1 -: 4];
			frame     <= {frame[FRAME_BITS-5:0], 4'h0};
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			tx_busy   <= 1'b0;
			tx_strobe <= 1'b0;
			tx_done   <= 1'b0;
			nib_cnt   <= '0;
		end else if (accept) begin
			tx_busy   <= 1'b1;
			tx_strobe <= 1'b1;   // First nibble goes out next cycle
			tx_done   <= 1'b0;
			nib_cnt   <= NIB_W'(1);
		end else if (tx_busy) begin
			if (nib_cnt == NIB_LAST) begin
				tx_busy   <= 1'b0;
				tx_strobe <= 1'b0;
				tx_done   <= 1'b0;
			end else begin
				tx_strobe <= 1'b1;
				tx_done   <= (nib_cnt == NIB_PEN);
				nib_cnt   <= nib_cnt + 1'b1;
			end
		end
	end

	// A frame ends with tx_done on its last nibble, then busy drops
	a_frame_length: assert property (@(posedge intclk) disable iff (!rst_n)
		$rose(tx_busy) |-> ##(FRAME_NIBBLES - 1) (tx_done && tx_strobe) ##1 !tx_busy)
		else $error("frame did not end with tx_done after %0d nibbles", FRAME_NIBBLES);

endmodule

/* xc_top.sv */
// ####################
// Correlator top level
// Sampler, lanes, packer
// ####################

`timescale 1ns/1ns

`include "xc_cfg.svh"

module xc_top (
	input  logic                  intclk,
	input  logic                  rst_n,
	input  logic                  smp_en,
	input  xc_types_pkg::sample_t line_in,
	input  xc_types_pkg::sample_t invert,
	input  logic                  integrate,
	output xc_frame_pkg::nibble_t tx_nibble,
	output logic                  tx_strobe,
	output logic                  tx_busy,
	output logic                  tx_done
);

	localparam int NL      = `XC_NUM_LINES;
	localparam int LANE_W  = `XC_LAG_AUTO * `XC_RESOLUTION;

	xc_types_pkg::sample_t     sample;
	logic                      sample_valid;
	logic                      counting;
	logic                      win_start;
	logic                      win_end;
	logic [NL*LANE_W-1:0]      auto_flat;
	logic [NL*`XC_RESOLUTION-1:0] cross_flat;

	xc_sampler u_sampler (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.smp_en       (smp_en),
		.line_in      (line_in),
		.invert       (invert),
		.integrate    (integrate),
		.sample       (sample),
		.sample_valid (sample_valid),
		.counting     (counting),
		.win_start    (win_start),
		.win_end      (win_end)
	);

	// Lane i pairs with line i+1, last one wraps to line 0
	for (genvar i = 0; i < NL; i++) begin : lanes
		xc_lane u_lane (
			.intclk        (intclk),
			.rst_n         (rst_n),
			.sample_bit    (sample[i]),
			.neighbour_bit (sample[(i+1) % NL]),
			.sample_valid  (sample_valid),
			.counting      (counting),
			.win_start     (win_start),
			.auto_counts   (auto_flat[i*LANE_W +: LANE_W]),
			.cross_count   (cross_flat[i*`XC_RESOLUTION +: `XC_RESOLUTION])
		);
	end

	xc_packer u_packer (
		.intclk       (intclk),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.counting     (counting),
		.win_end      (win_end),
		.auto_flat    (auto_flat),
		.cross_flat   (cross_flat),
		.tx_nibble    (tx_nibble),
		.tx_busy      (tx_busy),
		.tx_strobe    (tx_strobe),
		.tx_done      (tx_done)
	);

endmodule

/* xc_tb.sv */
// ####################
// Correlator testbench
// Window table, xorshift line stimulus
// Reference model, frame monitor, timeout
// ####################

`timescale 1ns/1ns

`include "xc_cfg.svh"

module xc_tb;

	localparam int NL          = `XC_NUM_LINES;
	localparam int LAG         = `XC_LAG_AUTO;
	localparam int RES         = `XC_RESOLUTION;
	localparam int NIBS        = `XC_FRAME_NIBBLES;
	localparam int FBITS       = NIBS * 4;
	localparam int TOT_W       = `XC_TOTAL_BITS;
	localparam int NROWS       = 7;
	localparam int PRE_SAMPLES = 30;
	localparam int CNT_MAX     = (1 << RES) - 1;
	localparam int TOT_MAX     = (1 << TOT_W) - 1;

	logic                  intclk;
	logic                  rst_n;
	logic                  smp_en;
	logic                  integrate;
	xc_types_pkg::sample_t line_in;
	xc_types_pkg::sample_t invert;
	xc_frame_pkg::nibble_t tx_nibble;
	logic                  tx_strobe;
	logic                  tx_busy;
	logic                  tx_done;

	// Window table, one row per window
	int                    row_win [NROWS];
	xc_types_pkg::sample_t row_inv [NROWS];
	int                    row_gap [NROWS];
	int                    row_off [NROWS];
	bit                    row_high [NROWS];
	int                    nrows;

	// Reference model state
	logic [LAG-1:1]   past [NL];        // past[i][k] is line i, k samples back
	int               cnt [NL][LAG+1];  // Lag counts, cross count on top
	int               total;
	logic             prev_level;
	int               last_accept;
	logic [FBITS-1:0] exp_q [$];
	logic [FBITS-1:0] exp_f;

	int               drv_tick;
	int               cyc;
	int               limit;
	int               value_errs;
	int               proto_errs;
	logic [31:0]      rng;
	logic [FBITS-1:0] rx;
	int               nib_pos;
	bit               idle_check;
	int               waited;

	xc_top uut (
		.intclk    (intclk),
		.rst_n     (rst_n),
		.smp_en    (smp_en),
		.line_in   (line_in),
		.invert    (invert),
		.integrate (integrate),
		.tx_nibble (tx_nibble),
		.tx_strobe (tx_strobe),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done)
	);

	always #50 intclk = ~intclk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_row(input int w, input xc_types_pkg::sample_t inv, input int gap,
			input int off, input bit high);
		row_win[nrows]  = w;
		row_inv[nrows]  = inv;
		row_gap[nrows]  = gap;
		row_off[nrows]  = off;
		row_high[nrows] = high;
		nrows++;
	endtask

	task automatic check_count(input string name, input xc_types_pkg::count_t got,
			input xc_types_pkg::count_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_nibble(input string name, input xc_frame_pkg::nibble_t got,
			input xc_frame_pkg::nibble_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_header(input string name, input xc_frame_pkg::sample_total_t got,
			input xc_frame_pkg::sample_total_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_frame(input logic [FBITS-1:0] got, input logic [FBITS-1:0] exp);
		int base;
		check_header("tx_nibble header total", got[FBITS-1 -: TOT_W], exp[FBITS-1 -: TOT_W]);
		for (int n = 0; n < `XC_GEOM_BITS / 4; n++) begin
			base = FBITS - TOT_W - 1 - 4 * n;
			check_nibble($sformatf("tx_nibble geometry %0d", n), got[base -: 4], exp[base -: 4]);
		end
		for (int j = 0; j < NL * (LAG + 1); j++) begin
			base = FBITS - `XC_HDR_BITS - 1 - RES * j;
			check_count($sformatf("tx_nibble lane %0d field %0d", j / (LAG + 1), j % (LAG + 1)),
				got[base -: RES], exp[base -: RES]);
		end
	endtask

	// Window closed, frame goes out unless the packer is still busy
	task automatic model_close();
		logic [FBITS-1:0] f;
		f = '0;
		f = {f[FBITS-TOT_W-1:0], xc_frame_pkg::sample_total_t'(total)};
		f = {f[FBITS-(`XC_GEOM_BITS/2)-1:0], (`XC_GEOM_BITS/2)'(NL)};
		f = {f[FBITS-(`XC_GEOM_BITS/2)-1:0], (`XC_GEOM_BITS/2)'(LAG)};
		for (int i = 0; i < NL; i++)
			for (int k = 0; k <= LAG; k++)
				f = {f[FBITS-RES-1:0], xc_types_pkg::count_t'(cnt[i][k])};
		if (drv_tick - last_accept > NIBS) begin
			exp_q.push_back(f);
			last_accept = drv_tick;
		end
	endtask

	task automatic model_sample(input xc_types_pkg::sample_t b, input logic level);
		logic tap;
		if (level && !prev_level) begin
			total = 0;
			for (int i = 0; i < NL; i++)
				for (int k = 0; k <= LAG; k++)
					cnt[i][k] = 0;
		end
		if (!level && prev_level)
			model_close();
		if (level) begin
			if (total < TOT_MAX)
				total++;
			for (int i = 0; i < NL; i++) begin
				if (b[i]) begin
					for (int k = 0; k < LAG; k++) begin
						tap = (k == 0) ? 1'b1 : past[i][k];
						if (tap && cnt[i][k] < CNT_MAX)
							cnt[i][k]++;
					end
					if (b[(i + 1) % NL] && cnt[i][LAG] < CNT_MAX)
						cnt[i][LAG]++;   // Neighbour, line 3 wraps to 0
				end
			end
		end
		for (int i = 0; i < NL; i++)
			past[i] = {past[i][LAG-2:1], b[i]};
		prev_level = level;
	endtask

	task automatic drive_sample(input logic level, input xc_types_pkg::sample_t inv,
			input int gap, input bit high);
		xc_types_pkg::sample_t bits;
		rng  = xorshift32(rng);
		bits = high ? '1 : rng[NL-1:0];
		@(posedge intclk);
		smp_en    <= 1'b1;
		line_in   <= bits;
		invert    <= inv;
		integrate <= level;
		drv_tick++;
		model_sample(bits ^ inv, level);
		for (int g = 1; g < gap; g++) begin
			@(posedge intclk);
			smp_en <= 1'b0;
			drv_tick++;
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int c = 0; c < n; c++) begin
			@(posedge intclk);
			smp_en <= 1'b0;
			drv_tick++;
		end
	endtask

	// Frame monitor, outputs are settled at the falling edge
	always @(negedge intclk) begin
		if (rst_n) begin
			if (idle_check && (tx_strobe || tx_busy || tx_done)) begin
				proto_errs++;
				$display("Frame output active although no window was integrated");
			end
			if (tx_strobe) begin
				if (exp_q.size() == 0) begin
					proto_errs++;
					$display("tx_strobe high outside an expected frame");
				end else begin
					rx = {rx[FBITS-5:0], tx_nibble};
					nib_pos++;
					if (nib_pos == NIBS) begin
						if (!tx_done) begin
							proto_errs++;
							$display("tx_done missing on the last nibble of a frame");
						end
						exp_f = exp_q.pop_front();
						compare_frame(rx, exp_f);
						nib_pos = 0;
					end else if (tx_done) begin
						proto_errs++;
						$display("tx_done raised early at nibble %0d", nib_pos);
					end
				end
			end else if (tx_done) begin
				proto_errs++;
				$display("tx_done high without tx_strobe");
			end
		end
	end

	always @(posedge intclk) begin
		cyc <= cyc + 1;
		if (cyc > limit) begin
			$display("Timeout, run exceeded %0d cycles", limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		intclk      = 1'b0;
		rst_n       = 1'b0;
		smp_en      = 1'b0;
		line_in     = '0;
		invert      = '0;
		integrate   = 1'b0;
		rng         = 32'd62;
		nrows       = 0;
		cyc         = 0;
		drv_tick    = 0;
		value_errs  = 0;
		proto_errs  = 0;
		nib_pos     = 0;
		rx          = '0;
		idle_check  = 1'b0;
		total       = 0;
		prev_level  = 1'b0;
		last_accept = -1000000;
		for (int i = 0; i < NL; i++) begin
			past[i] = '0;
			for (int k = 0; k <= LAG; k++)
				cnt[i][k] = 0;
		end

		add_row(40, 4'b0000, 1, 10, 0);
		add_row(60, 4'b0101, 3, 20, 0);
		add_row(30, 4'b1111, 2, 8, 0);      // Short gap before the next window
		add_row(5, 4'b0000, 1, 60, 0);      // Ends mid-frame, dropped
		add_row(50, 4'b1000, 1, 60, 0);
		add_row(70000, 4'b0000, 1, 100, 1); // All lines high, counters saturate
		add_row(20, 4'b0110, 2, 60, 0);

		limit = 8 + PRE_SAMPLES + 10 + 4 * NIBS + 1000;
		for (int r = 0; r < nrows; r++)
			limit += (row_win[r] + row_off[r]) * row_gap[r];

		repeat (8) @(posedge intclk);
		rst_n <= 1'b1;

		// Samples with integrate low must leave the frame side idle
		idle_check = 1'b1;
		for (int s = 0; s < PRE_SAMPLES; s++)
			drive_sample(1'b0, '0, 1, 1'b0);
		wait_cycles(10);
		idle_check = 1'b0;

		for (int r = 0; r < nrows; r++) begin
			for (int s = 0; s < row_win[r]; s++)
				drive_sample(1'b1, row_inv[r], row_gap[r], row_high[r]);
			for (int s = 0; s < row_off[r]; s++)
				drive_sample(1'b0, row_inv[r], row_gap[r], row_high[r]);
		end
		wait_cycles(1);

		waited = 0;
		while ((exp_q.size() != 0 || nib_pos != 0) && waited < 4 * NIBS) begin
			@(posedge intclk);
			waited++;
		end
		if (exp_q.size() != 0) begin
			proto_errs++;
			$display("%0d expected frame(s) never completed", exp_q.size());
		end
		repeat (4) @(posedge intclk);

		$display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+.
xc_types_pkg.sv
xc_frame_pkg.sv
xc_sampler.sv
xc_lane.sv
xc_packer.sv
xc_top.sv
xc_tb.sv
